/* design/cnn_load_pkg.sv */
// shared widths, counts and word tags for the cnn loader, referenced by scoped name
package cnn_load_pkg;

	// one pixel or weight
	localparam int DATA_WIDTH = 8;

	// one dma beat from external memory
	localparam int BEAT_WIDTH = 16;

	// three beats make one packed word of six bytes
	localparam int BEATS_PER_WORD = 3;
	localparam int WORD_WIDTH = BEAT_WIDTH * BEATS_PER_WORD;

	// weight memory columns, also the width of the column one-hot
	localparam int COLUMN_NUM = 6;

	// kernel mode code
	// 0: 3x3 quad, 1: 4x4, 2: 5x5, 3: 6x6
	localparam int MODE_WIDTH = 2;

	// filter count field, zmove+1 filters per run
	localparam int ZMOVE_WIDTH = 7;

	// tag carried next to each word
	localparam int KIND_WIDTH = 2;

	// image word, goes to the image buffer
	localparam logic [KIND_WIDTH-1:0] KIND_IMG = 2'd0;

	// weight word, one column of a filter
	localparam logic [KIND_WIDTH-1:0] KIND_WGT = 2'd1;

	// bias beat, only the low byte is meaningful
	localparam logic [KIND_WIDTH-1:0] KIND_BIAS = 2'd2;

endpackage

/* design/dma_fetch.sv */
// fetch side of the loader, reads dma beats and hands tagged words to the FIFO
`timescale 1ns/1ps

module dma_fetch #(
	parameter int DMA_ADDR_WIDTH = 10,
	parameter int IMEM_ADDR_WIDTH = 10
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_start,
	input  logic [cnn_load_pkg::MODE_WIDTH-1:0]   i_mode,
	input  logic [cnn_load_pkg::ZMOVE_WIDTH-1:0]  i_zmove,
	input  logic [IMEM_ADDR_WIDTH-1:0]            i_img_words,
	input  logic [DMA_ADDR_WIDTH-1:0]             i_dma_img_base,
	input  logic [DMA_ADDR_WIDTH-1:0]             i_dma_wgt_base,
	input  logic                                  i_dma_rd_ready,
	input  logic [cnn_load_pkg::BEAT_WIDTH-1:0]   i_dma_rd_data,
	output logic                                  o_dma_rd_en,
	output logic [DMA_ADDR_WIDTH-1:0]             o_dma_rd_addr,
	output logic                                  o_word_valid,
	input  logic                                  i_word_ready,
	output logic [cnn_load_pkg::WORD_WIDTH-1:0]   o_word_data,
	output logic [cnn_load_pkg::KIND_WIDTH-1:0]   o_word_kind
);
	localparam int COL_CNT_WIDTH = $clog2(cnn_load_pkg::COLUMN_NUM + 1);
	localparam int BUF_WIDTH = cnn_load_pkg::WORD_WIDTH - cnn_load_pkg::BEAT_WIDTH;
	localparam logic [1:0] LAST_BEAT = 2'(cnn_load_pkg::BEATS_PER_WORD - 1);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_IMG = 2'd1;
	localparam logic [1:0] ST_WGT = 2'd2;

	logic [1:0] state;
	logic [1:0] beat_cnt;
	logic bias_next;
	logic [IMEM_ADDR_WIDTH-1:0] img_cnt;
	logic [COL_CNT_WIDTH-1:0] col_cnt;
	logic [COL_CNT_WIDTH-1:0] col_num;
	logic [cnn_load_pkg::ZMOVE_WIDTH-1:0] filt_cnt;
	logic [BUF_WIDTH-1:0] beat_buf;
	logic word_stall;
	logic beat_ok;
	logic bias_beat;
	logic pack_beat;
	logic last_beat;

	// same column rule as the writer, tells where a filter ends
	always_comb begin
		case (i_mode)
			2'd1: col_num = COL_CNT_WIDTH'(4);
			2'd2: col_num = COL_CNT_WIDTH'(5);
			default: col_num = COL_CNT_WIDTH'(cnn_load_pkg::COLUMN_NUM);
		endcase
	end

	// hold off the dma while a finished word waits on a full fifo
	assign word_stall = o_word_valid && !i_word_ready;
	assign o_dma_rd_en = (state != ST_IDLE) && !word_stall;

	assign beat_ok = o_dma_rd_en && i_dma_rd_ready;
	assign bias_beat = beat_ok && bias_next;
	assign pack_beat = beat_ok && !bias_next;
	assign last_beat = pack_beat && (beat_cnt == LAST_BEAT);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= ST_IDLE;
			o_dma_rd_addr <= '0;
			beat_cnt <= '0;
			bias_next <= 1'b0;
			img_cnt <= '0;
			col_cnt <= '0;
			filt_cnt <= '0;
			o_word_valid <= 1'b0;
		end else begin
			if (last_beat || bias_beat) begin
				o_word_valid <= 1'b1;
			end else if (i_word_ready) begin
				o_word_valid <= 1'b0;
			end

			if (pack_beat) begin
				beat_cnt <= last_beat ? 2'd0 : beat_cnt + 2'd1;
			end

			case (state)
				ST_IDLE: begin
					if (i_start) begin
						img_cnt <= '0;
						col_cnt <= '0;
						filt_cnt <= '0;
						// no image words means straight to the weights
						if (i_img_words == '0) begin
							state <= ST_WGT;
							o_dma_rd_addr <= i_dma_wgt_base;
							bias_next <= 1'b1;
						end else begin
							state <= ST_IMG;
							o_dma_rd_addr <= i_dma_img_base;
						end
					end
				end
				ST_IMG: begin
					if (beat_ok) begin
						o_dma_rd_addr <= o_dma_rd_addr + 1'b1;
					end
					if (last_beat) begin
						img_cnt <= img_cnt + 1'b1;
						if (img_cnt == i_img_words - 1'b1) begin
							state <= ST_WGT;
							o_dma_rd_addr <= i_dma_wgt_base;
							bias_next <= 1'b1;
						end
					end
				end
				ST_WGT: begin
					if (beat_ok) begin
						o_dma_rd_addr <= o_dma_rd_addr + 1'b1;
					end
					if (bias_beat) begin
						bias_next <= 1'b0;
					end
					if (last_beat) begin
						if (col_cnt == col_num - 1'b1) begin
							col_cnt <= '0;
							if (filt_cnt == i_zmove) begin
								state <= ST_IDLE;
							end else begin
								filt_cnt <= filt_cnt + 1'b1;
								bias_next <= 1'b1;
							end
						end else begin
							col_cnt <= col_cnt + 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// lowest beat ends up in the lowest bits
	always_ff @(posedge i_clk) begin
		if (pack_beat) begin
			beat_buf <= {i_dma_rd_data, beat_buf[BUF_WIDTH-1:cnn_load_pkg::BEAT_WIDTH]};
		end
		if (last_beat) begin
			o_word_data <= {i_dma_rd_data, beat_buf};
			o_word_kind <= (state == ST_IMG) ? cnn_load_pkg::KIND_IMG : cnn_load_pkg::KIND_WGT;
		end else if (bias_beat) begin
			o_word_data <= cnn_load_pkg::WORD_WIDTH'(i_dma_rd_data);
			o_word_kind <= cnn_load_pkg::KIND_BIAS;
		end
	end

endmodule

/* design/word_fifo.sv */
// small FIFO of tagged words between the fetch unit and the buffer writer
`timescale 1ns/1ps

module word_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                 i_clk,
	input  logic                                 i_rst,
	input  logic                                 i_valid,
	output logic                                 o_ready,
	input  logic [cnn_load_pkg::WORD_WIDTH-1:0]  i_data,
	input  logic [cnn_load_pkg::KIND_WIDTH-1:0]  i_kind,
	output logic                                 o_valid,
	input  logic                                 i_ready,
	output logic [cnn_load_pkg::WORD_WIDTH-1:0]  o_data,
	output logic [cnn_load_pkg::KIND_WIDTH-1:0]  o_kind
);
	localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
	localparam int ENTRY_WIDTH = cnn_load_pkg::KIND_WIDTH + cnn_load_pkg::WORD_WIDTH;

	// kind sits above the data in each entry
	logic [ENTRY_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign o_ready = (count != CNT_WIDTH'(FIFO_DEPTH));
	assign o_valid = (count != '0);
	assign push = i_valid && o_ready;
	assign pop = o_valid && i_ready;
	assign {o_kind, o_data} = mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr] <= {i_kind, i_data};
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* design/buffer_writer.sv */
// drains tagged words into the image buffer, the weight columns and the bias register
`timescale 1ns/1ps

module buffer_writer #(
	parameter int IMEM_ADDR_WIDTH = 10,
	parameter int WMEM_ADDR_WIDTH = 7
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_start,
	input  logic [cnn_load_pkg::MODE_WIDTH-1:0]   i_mode,
	input  logic [cnn_load_pkg::ZMOVE_WIDTH-1:0]  i_zmove,
	input  logic                                  i_valid,
	output logic                                  o_ready,
	input  logic [cnn_load_pkg::WORD_WIDTH-1:0]   i_data,
	input  logic [cnn_load_pkg::KIND_WIDTH-1:0]   i_kind,
	input  logic                                  i_mem_ready,
	output logic                                  o_img_wr_en,
	output logic [IMEM_ADDR_WIDTH-1:0]            o_img_wr_addr,
	output logic [cnn_load_pkg::WORD_WIDTH-1:0]   o_img_wr_data,
	output logic [cnn_load_pkg::COLUMN_NUM-1:0]   o_wmem_wr_en,
	output logic [WMEM_ADDR_WIDTH-1:0]            o_wmem_wr_addr,
	output logic [cnn_load_pkg::WORD_WIDTH-1:0]   o_wmem_wr_data,
	output logic [cnn_load_pkg::DATA_WIDTH-1:0]   o_bias,
	output logic                                  o_update_bias,
	output logic                                  o_done
);
	localparam int COL_IDX_WIDTH = $clog2(cnn_load_pkg::COLUMN_NUM);

	logic take;
	logic take_img;
	logic take_wgt;
	logic take_bias;
	logic [COL_IDX_WIDTH-1:0] last_col;
	logic [cnn_load_pkg::COLUMN_NUM-1:0] col_sel;
	logic [IMEM_ADDR_WIDTH-1:0] img_cnt;
	logic [cnn_load_pkg::ZMOVE_WIDTH-1:0] filt_idx;

	// last weight column per kernel mode
	// 3x3 quad and 6x6 fill all six, 4x4 four, 5x5 five
	always_comb begin
		case (i_mode)
			2'd1: last_col = COL_IDX_WIDTH'(3);
			2'd2: last_col = COL_IDX_WIDTH'(4);
			default: last_col = COL_IDX_WIDTH'(cnn_load_pkg::COLUMN_NUM - 1);
		endcase
	end

	assign o_ready = i_mem_ready;
	assign take = i_valid && i_mem_ready;
	assign take_img = take && (i_kind == cnn_load_pkg::KIND_IMG);
	assign take_wgt = take && (i_kind == cnn_load_pkg::KIND_WGT);
	assign take_bias = take && (i_kind == cnn_load_pkg::KIND_BIAS);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_img_wr_en <= 1'b0;
			o_wmem_wr_en <= '0;
			o_update_bias <= 1'b0;
			o_done <= 1'b0;
			img_cnt <= '0;
			col_sel <= cnn_load_pkg::COLUMN_NUM'(1);
			filt_idx <= '0;
		end else begin
			// write strobes last one cycle each
			o_img_wr_en <= take_img;
			o_wmem_wr_en <= take_wgt ? col_sel : '0;
			o_update_bias <= take_bias;

			if (i_start) begin
				img_cnt <= '0;
				col_sel <= cnn_load_pkg::COLUMN_NUM'(1);
				filt_idx <= '0;
				o_done <= 1'b0;
			end else begin
				if (take_img) begin
					img_cnt <= img_cnt + 1'b1;
				end
				if (take_wgt) begin
					if (col_sel[last_col]) begin
						// filter complete, next row of the weight memory
						col_sel <= cnn_load_pkg::COLUMN_NUM'(1);
						filt_idx <= filt_idx + 1'b1;
						if (filt_idx == i_zmove) begin
							o_done <= 1'b1;
						end
					end else begin
						col_sel <= col_sel << 1;
					end
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (take_img) begin
			o_img_wr_addr <= img_cnt;
			o_img_wr_data <= i_data;
		end
		if (take_wgt) begin
			o_wmem_wr_addr <= WMEM_ADDR_WIDTH'(filt_idx);
			o_wmem_wr_data <= i_data;
		end
		if (take_bias) begin
			o_bias <= i_data[cnn_load_pkg::DATA_WIDTH-1:0];
		end
	end

endmodule

/* design/cnn_load_top.sv */
// loader top level, connects dma fetch, word FIFO and buffer writer
`timescale 1ns/1ps

module cnn_load_top #(
	parameter int DMA_ADDR_WIDTH = 10,
	parameter int IMEM_ADDR_WIDTH = 10,
	parameter int WMEM_ADDR_WIDTH = 7,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_start,
	input  logic [cnn_load_pkg::MODE_WIDTH-1:0]   i_mode,
	input  logic [cnn_load_pkg::ZMOVE_WIDTH-1:0]  i_zmove,
	input  logic [IMEM_ADDR_WIDTH-1:0]            i_img_words,
	input  logic [DMA_ADDR_WIDTH-1:0]             i_dma_img_base,
	input  logic [DMA_ADDR_WIDTH-1:0]             i_dma_wgt_base,
	input  logic                                  i_dma_rd_ready,
	input  logic [cnn_load_pkg::BEAT_WIDTH-1:0]   i_dma_rd_data,
	output logic                                  o_dma_rd_en,
	output logic [DMA_ADDR_WIDTH-1:0]             o_dma_rd_addr,
	input  logic                                  i_mem_ready,
	output logic                                  o_img_wr_en,
	output logic [IMEM_ADDR_WIDTH-1:0]            o_img_wr_addr,
	output logic [cnn_load_pkg::WORD_WIDTH-1:0]   o_img_wr_data,
	output logic [cnn_load_pkg::COLUMN_NUM-1:0]   o_wmem_wr_en,
	output logic [WMEM_ADDR_WIDTH-1:0]            o_wmem_wr_addr,
	output logic [cnn_load_pkg::WORD_WIDTH-1:0]   o_wmem_wr_data,
	output logic [cnn_load_pkg::DATA_WIDTH-1:0]   o_bias,
	output logic                                  o_update_bias,
	output logic                                  o_done
);
	// fetch to fifo
	logic fetch_valid;
	logic fetch_ready;
	logic [cnn_load_pkg::WORD_WIDTH-1:0] fetch_data;
	logic [cnn_load_pkg::KIND_WIDTH-1:0] fetch_kind;

	// fifo to writer
	logic wr_valid;
	logic wr_ready;
	logic [cnn_load_pkg::WORD_WIDTH-1:0] wr_data;
	logic [cnn_load_pkg::KIND_WIDTH-1:0] wr_kind;

	dma_fetch #(
		.DMA_ADDR_WIDTH  (DMA_ADDR_WIDTH),
		.IMEM_ADDR_WIDTH (IMEM_ADDR_WIDTH)
	) u_dma_fetch (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start        (i_start),
		.i_mode         (i_mode),
		.i_zmove        (i_zmove),
		.i_img_words    (i_img_words),
		.i_dma_img_base (i_dma_img_base),
		.i_dma_wgt_base (i_dma_wgt_base),
		.i_dma_rd_ready (i_dma_rd_ready),
		.i_dma_rd_data  (i_dma_rd_data),
		.o_dma_rd_en    (o_dma_rd_en),
		.o_dma_rd_addr  (o_dma_rd_addr),
		.o_word_valid   (fetch_valid),
		.i_word_ready   (fetch_ready),
		.o_word_data    (fetch_data),
		.o_word_kind    (fetch_kind)
	);

	word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_word_fifo (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_valid (fetch_valid),
		.o_ready (fetch_ready),
		.i_data  (fetch_data),
		.i_kind  (fetch_kind),
		.o_valid (wr_valid),
		.i_ready (wr_ready),
		.o_data  (wr_data),
		.o_kind  (wr_kind)
	);

	buffer_writer #(
		.IMEM_ADDR_WIDTH (IMEM_ADDR_WIDTH),
		.WMEM_ADDR_WIDTH (WMEM_ADDR_WIDTH)
	) u_buffer_writer (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start        (i_start),
		.i_mode         (i_mode),
		.i_zmove        (i_zmove),
		.i_valid        (wr_valid),
		.o_ready        (wr_ready),
		.i_data         (wr_data),
		.i_kind         (wr_kind),
		.i_mem_ready    (i_mem_ready),
		.o_img_wr_en    (o_img_wr_en),
		.o_img_wr_addr  (o_img_wr_addr),
		.o_img_wr_data  (o_img_wr_data),
		.o_wmem_wr_en   (o_wmem_wr_en),
		.o_wmem_wr_addr (o_wmem_wr_addr),
		.o_wmem_wr_data (o_wmem_wr_data),
		.o_bias         (o_bias),
		.o_update_bias  (o_update_bias),
		.o_done         (o_done)
	);

endmodule

/* bench/clock_gen.sv */
// testbench clock and active low reset source, instantiated once by the testbench
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RST_CYCLES = 16
) (
	output logic o_clk,
	output logic o_rst
);
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// reset held low for a fixed number of clocks
	initial begin
		o_rst = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst <= 1'b1;
	end

endmodule

/* bench/cnn_load_assertions.sv */
// handshake and strobe assertions, bound into the loader top level by the bind below
`timescale 1ns/1ps

module cnn_load_assertions #(
	parameter int ADDR_WIDTH = 10
) (
	input logic                                 i_clk,
	input logic                                 i_rst,
	input logic                                 i_rd_en,
	input logic                                 i_rd_ready,
	input logic [ADDR_WIDTH-1:0]                i_rd_addr,
	input logic [cnn_load_pkg::COLUMN_NUM-1:0]  i_wmem_wr_en,
	input logic                                 i_update_bias
);
	// a stalled dma request keeps its address
	assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_rd_en && !i_rd_ready) |=> $stable(i_rd_addr))
		else $error("dma read address moved while the request was stalled");

	// at most one weight column per write
	assert property (@(posedge i_clk) disable iff (!i_rst) $onehot0(i_wmem_wr_en))
		else $error("weight column enable is not one-hot");

	assert property (@(posedge i_clk) disable iff (!i_rst) i_update_bias |=> !i_update_bias)
		else $error("bias update strobe lasted two cycles");

endmodule

bind cnn_load_top cnn_load_assertions #(
	.ADDR_WIDTH (DMA_ADDR_WIDTH)
) u_cnn_load_assertions (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_rd_en       (o_dma_rd_en),
	.i_rd_ready    (i_dma_rd_ready),
	.i_rd_addr     (o_dma_rd_addr),
	.i_wmem_wr_en  (o_wmem_wr_en),
	.i_update_bias (o_update_bias)
);

/* bench/cnn_load_tb.sv */
// testbench for the cnn loader, runs a table of load jobs against a dma model and scoreboard
`timescale 1ns/1ps

module cnn_load_tb;
	localparam int NUM_ROWS = 6;
	localparam int WW = cnn_load_pkg::WORD_WIDTH;

	// job table: mode, zmove, image words, image base, weight base, weight writes per filter
	int tbl_mode [NUM_ROWS] = '{0, 1, 2, 3, 1, 0};
	int tbl_zmove [NUM_ROWS] = '{1, 2, 0, 3, 0, 4};
	int tbl_img [NUM_ROWS] = '{4, 3, 2, 5, 0, 8};
	int tbl_img_base [NUM_ROWS] = '{'h010, 'h040, 'h080, 'h020, 'h000, 'h200};
	int tbl_wgt_base [NUM_ROWS] = '{'h100, 'h200, 'h300, 'h180, 'h050, 'h2a0};
	int tbl_cols [NUM_ROWS] = '{6, 4, 5, 6, 4, 6};

	logic clk, rst, start, mem_ready, dma_rd_ready;
	logic [1:0] mode;
	logic [6:0] zmove;
	logic [9:0] img_words, img_base, wgt_base, dma_rd_addr, img_wr_addr;
	logic [15:0] dma_rd_data;
	logic dma_rd_en, img_wr_en, update_bias, done;
	logic [WW-1:0] img_wr_data, wmem_wr_data;
	logic [5:0] wmem_wr_en;
	logic [6:0] wmem_wr_addr;
	logic [7:0] bias;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int fail_tests = 0;
	int timeout_limit;

	clock_gen #(.PERIOD_NS(4), .RST_CYCLES(16)) u_clock_gen (.o_clk(clk), .o_rst(rst));

	cnn_load_top i_cnn_load_top (
		.i_clk(clk), .i_rst(rst), .i_start(start), .i_mode(mode), .i_zmove(zmove),
		.i_img_words(img_words), .i_dma_img_base(img_base), .i_dma_wgt_base(wgt_base),
		.i_dma_rd_ready(dma_rd_ready), .i_dma_rd_data(dma_rd_data),
		.o_dma_rd_en(dma_rd_en), .o_dma_rd_addr(dma_rd_addr), .i_mem_ready(mem_ready),
		.o_img_wr_en(img_wr_en), .o_img_wr_addr(img_wr_addr), .o_img_wr_data(img_wr_data),
		.o_wmem_wr_en(wmem_wr_en), .o_wmem_wr_addr(wmem_wr_addr),
		.o_wmem_wr_data(wmem_wr_data), .o_bias(bias), .o_update_bias(update_bias),
		.o_done(done)
	);

	// fixed pattern over the whole 10-bit address
	function automatic logic [15:0] beat_data(input int addr);
		logic [15:0] a;
		a = 16'(addr & 'h3ff);
		return (a * 16'd421) ^ 16'h5ac3;
	endfunction

	// three beats, lowest address in the lowest bits
	function automatic logic [WW-1:0] word_at(input int addr);
		return {beat_data(addr + 2), beat_data(addr + 1), beat_data(addr)};
	endfunction

	function automatic int row_beats(input int r);
		return tbl_img[r] * 3 + (tbl_zmove[r] + 1) * (1 + 3 * tbl_cols[r]);
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("CHECK FAILED %s got %h exp %h", name, got, exp);
		err_cnt++;
	endtask

	// memory answers in the same cycle for the address shown
	always_comb dma_rd_data = beat_data(int'(dma_rd_addr));

	// random ready on both memory sides, one seeded stream for the whole run
	initial begin
		void'($urandom(79467));
		dma_rd_ready = 1'b0;
		mem_ready = 1'b0;
		forever begin
			@(posedge clk);
			dma_rd_ready <= ($urandom % 4) != 0;
			// slow writer side keeps the FIFO near full and stalls the fetch
			mem_ready <= ($urandom % 4) == 0;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic run_row(input int r);
		int stride, exp_addr, beats, img_seen, filt, col, bias_seen, cyc, errs_before;
		logic done_seen;
		errs_before = err_cnt;
		stride = 1 + 3 * tbl_cols[r];
		exp_addr = (tbl_img[r] == 0) ? tbl_wgt_base[r] : tbl_img_base[r];
		beats = 0;
		img_seen = 0;
		filt = 0;
		col = 0;
		bias_seen = 0;
		cyc = 0;
		done_seen = 1'b0;
		@(posedge clk);
		mode <= 2'(tbl_mode[r]);
		zmove <= 7'(tbl_zmove[r]);
		img_words <= 10'(tbl_img[r]);
		img_base <= 10'(tbl_img_base[r]);
		wgt_base <= 10'(tbl_wgt_base[r]);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!done_seen) begin
			@(negedge clk);
			if (cyc == 0 && dma_rd_en !== 1'b1) begin
				$display("dma read enable did not rise one cycle after start");
				err_cnt++;
			end
			cyc++;
			if (dma_rd_en && dma_rd_ready) begin
				if (dma_rd_addr !== 10'(exp_addr))
					report_mismatch("o_dma_rd_addr", 64'(dma_rd_addr), 64'(10'(exp_addr)));
				beats++;
				exp_addr++;
				// weight region follows the last image beat
				if (beats == tbl_img[r] * 3)
					exp_addr = tbl_wgt_base[r];
			end
			if (img_wr_en) begin
				if (img_wr_addr !== 10'(img_seen))
					report_mismatch("o_img_wr_addr", 64'(img_wr_addr), 64'(img_seen));
				if (img_wr_data !== word_at(tbl_img_base[r] + 3 * img_seen))
					report_mismatch("o_img_wr_data", 64'(img_wr_data),
						64'(word_at(tbl_img_base[r] + 3 * img_seen)));
				img_seen++;
			end
			if (wmem_wr_en != '0) begin
				if (wmem_wr_en !== 6'(1 << col))
					report_mismatch("o_wmem_wr_en", 64'(wmem_wr_en), 64'(6'(1 << col)));
				if (wmem_wr_addr !== 7'(filt))
					report_mismatch("o_wmem_wr_addr", 64'(wmem_wr_addr), 64'(filt));
				if (wmem_wr_data !== word_at(tbl_wgt_base[r] + filt * stride + 1 + 3 * col))
					report_mismatch("o_wmem_wr_data", 64'(wmem_wr_data),
						64'(word_at(tbl_wgt_base[r] + filt * stride + 1 + 3 * col)));
				col++;
				if (col == tbl_cols[r]) begin
					col = 0;
					filt++;
				end
			end
			if (update_bias) begin
				if (bias !== 8'(beat_data(tbl_wgt_base[r] + bias_seen * stride)))
					report_mismatch("o_bias", 64'(bias),
						64'(8'(beat_data(tbl_wgt_base[r] + bias_seen * stride))));
				bias_seen++;
			end
			done_seen = (done === 1'b1);
		end
		if (filt != tbl_zmove[r] + 1)
			report_mismatch("filters written", 64'(filt), 64'(tbl_zmove[r] + 1));
		if (bias_seen != tbl_zmove[r] + 1)
			report_mismatch("o_update_bias count", 64'(bias_seen), 64'(tbl_zmove[r] + 1));
		if (img_seen != tbl_img[r])
			report_mismatch("o_img_wr_en count", 64'(img_seen), 64'(tbl_img[r]));
		if (beats != row_beats(r))
			report_mismatch("dma beats", 64'(beats), 64'(row_beats(r)));
		if (err_cnt != errs_before)
			fail_tests++;
		$display("test %0d mode %0d zmove %0d images %0d: %s", r, tbl_mode[r], tbl_zmove[r],
			tbl_img[r], (err_cnt == errs_before) ? "ok" : "errors");
	endtask

	// run limit from the total beat count of the table
	initial begin
		timeout_limit = 200;
		for (int r = 0; r < NUM_ROWS; r++)
			timeout_limit += row_beats(r) * 8;
		while (cycle_cnt < timeout_limit) @(negedge clk);
		$display("timeout after %0d cycles while waiting for o_done", cycle_cnt);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		start = 1'b0;
		mode = '0;
		zmove = '0;
		img_words = '0;
		img_base = '0;
		wgt_base = '0;
		@(posedge rst);
		repeat (2) @(posedge clk);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("tests %0d, failing tests %0d, check errors %0d", NUM_ROWS, fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* cnn_load_top.f */
design/cnn_load_pkg.sv
design/dma_fetch.sv
design/word_fifo.sv
design/buffer_writer.sv
design/cnn_load_top.sv
bench/clock_gen.sv
bench/cnn_load_assertions.sv
bench/cnn_load_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the loader testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module cnn_load_tb \
	-f cnn_load_top.f -o cnn_load_sim &&
./obj_dir/cnn_load_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASSED$" sim.log 2>/dev/null && exit 0 || exit 1
